// File: all.f
engine_pkg.sv
phys_reg_file.sv
reg_status_table.sv
free_list.sv
rename_stage.sv
reorder_buffer.sv
rename_engine.sv
rename_engine_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the rename engine testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module rename_engine_tb \
  -o rename_engine_sim \
  && ./obj_dir/rename_engine_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: rename_engine_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rename_engine_tb import engine_pkg::*; ();

  logic              core_clock;
  logic              rst_n;
  logic              ren_valid;
  logic              ren_has_dest;
  logic [AREG_W-1:0] ren_rs1;
  logic [AREG_W-1:0] ren_rs2;
  logic [AREG_W-1:0] ren_dest;
  logic              ren_stall;
  logic [PREG_W-1:0] ren_rs1_preg;
  logic [PREG_W-1:0] ren_rs2_preg;
  logic              ren_rs1_ready;
  logic              ren_rs2_ready;
  logic [PREG_W-1:0] ren_dest_preg;
  logic [ROB_W-1:0]  ren_rob_id;
  logic              wb0_valid;
  logic [ROB_W-1:0]  wb0_rob_id;
  logic              wb0_we;
  logic [PREG_W-1:0] wb0_preg;
  logic [XLEN-1:0]   wb0_data;
  logic              wb1_valid;
  logic [ROB_W-1:0]  wb1_rob_id;
  logic              wb1_we;
  logic [PREG_W-1:0] wb1_preg;
  logic [XLEN-1:0]   wb1_data;
  logic [PREG_W-1:0] rd0_preg;
  logic [XLEN-1:0]   rd0_data;
  logic [PREG_W-1:0] rd1_preg;
  logic [XLEN-1:0]   rd1_data;
  logic              commit_valid;
  logic [AREG_W-1:0] commit_arch;
  logic [PREG_W-1:0] commit_preg;

  // Reference model state
  logic [PREG_W-1:0]    map_m    [ARCH_REGS];
  logic [PREG_W-1:0]    free_m   [FREE_DEPTH];
  logic [4:0]           free_hd;
  logic [4:0]           free_tl;
  logic [PHYS_REGS-1:0] rdy_m;
  logic [XLEN-1:0]      val_m    [PHYS_REGS];
  logic [AREG_W-1:0]    rob_arch [ROB_DEPTH];
  logic [PREG_W-1:0]    rob_old  [ROB_DEPTH];
  logic [PREG_W-1:0]    rob_new  [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] rob_dest;
  logic [ROB_DEPTH-1:0] rob_done;
  logic [ROB_W-1:0]     rob_hd;
  logic [ROB_W-1:0]     rob_tl;
  logic [ROB_W:0]       rob_cnt;
  logic                 exp_cv;
  logic [AREG_W-1:0]    exp_carch;
  logic [PREG_W-1:0]    exp_cpreg;

  // Issued instructions, kept so that writebacks can target them later
  logic [ROB_W-1:0]  iss_rob  [64];
  logic [PREG_W-1:0] iss_preg [64];
  logic              iss_dest [64];
  int                n_iss;
  integer            seed;

  wire m_full   = (rob_cnt == 5'd16);
  wire m_dest   = ren_has_dest && (ren_dest != '0);
  wire m_acc    = ren_valid && !m_full;
  wire m_alloc  = m_acc && m_dest;
  wire m_retire = (rob_cnt != '0) && rob_done[rob_hd];

  rename_engine i_rename_engine (
    .core_clock_i    (core_clock),
    .rst_n_i         (rst_n),
    .ren_valid_i     (ren_valid),
    .ren_has_dest_i  (ren_has_dest),
    .ren_rs1_i       (ren_rs1),
    .ren_rs2_i       (ren_rs2),
    .ren_dest_i      (ren_dest),
    .ren_stall_o     (ren_stall),
    .ren_rs1_preg_o  (ren_rs1_preg),
    .ren_rs2_preg_o  (ren_rs2_preg),
    .ren_rs1_ready_o (ren_rs1_ready),
    .ren_rs2_ready_o (ren_rs2_ready),
    .ren_dest_preg_o (ren_dest_preg),
    .ren_rob_id_o    (ren_rob_id),
    .wb0_valid_i     (wb0_valid),
    .wb0_rob_id_i    (wb0_rob_id),
    .wb0_we_i        (wb0_we),
    .wb0_preg_i      (wb0_preg),
    .wb0_data_i      (wb0_data),
    .wb1_valid_i     (wb1_valid),
    .wb1_rob_id_i    (wb1_rob_id),
    .wb1_we_i        (wb1_we),
    .wb1_preg_i      (wb1_preg),
    .wb1_data_i      (wb1_data),
    .rd0_preg_i      (rd0_preg),
    .rd0_data_o      (rd0_data),
    .rd1_preg_i      (rd1_preg),
    .rd1_data_o      (rd1_data),
    .commit_valid_o  (commit_valid),
    .commit_arch_o   (commit_arch),
    .commit_preg_o   (commit_preg)
  );

  initial begin
    core_clock = 1'b0;
    forever #20 core_clock = ~core_clock;
  end

  // The model follows the rename, writeback and in-order commit rules
  always @(posedge core_clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < ARCH_REGS; i++) begin
        map_m[i] <= PREG_W'(i);
      end
      for (int i = 0; i < FREE_DEPTH; i++) begin
        free_m[i] <= PREG_W'(ARCH_REGS + i);
      end
      for (int i = 0; i < PHYS_REGS; i++) begin
        val_m[i] <= '0;
      end
      rdy_m     <= '1;
      free_hd   <= '0;
      free_tl   <= '0;
      rob_hd    <= '0;
      rob_tl    <= '0;
      rob_cnt   <= '0;
      rob_done  <= '0;
      exp_cv    <= 1'b0;
      exp_carch <= '0;
      exp_cpreg <= '0;
    end else begin
      if (m_acc) begin
        rob_arch[rob_tl] <= ren_dest;
        rob_old[rob_tl]  <= map_m[ren_dest];
        rob_new[rob_tl]  <= m_dest ? free_m[free_hd] : '0;
        rob_dest[rob_tl] <= m_dest;
        rob_done[rob_tl] <= 1'b0;
        rob_tl           <= rob_tl + 1'b1;
      end
      if (wb0_we) begin
        val_m[wb0_preg] <= wb0_data;
        rdy_m[wb0_preg] <= 1'b1;
      end
      if (wb1_we) begin
        val_m[wb1_preg] <= wb1_data;
        rdy_m[wb1_preg] <= 1'b1;
      end
      if (wb0_valid) begin
        rob_done[wb0_rob_id] <= 1'b1;
      end
      if (wb1_valid) begin
        rob_done[wb1_rob_id] <= 1'b1;
      end
      if (m_alloc) begin
        map_m[ren_dest]        <= free_m[free_hd];
        rdy_m[free_m[free_hd]] <= 1'b0;
        free_hd                <= free_hd + 1'b1;
      end
      exp_cv <= m_retire;
      if (m_retire) begin
        exp_carch <= rob_arch[rob_hd];
        exp_cpreg <= rob_new[rob_hd];
        rob_hd    <= rob_hd + 1'b1;
        if (rob_dest[rob_hd]) begin
          free_m[free_tl] <= rob_old[rob_hd];
          free_tl         <= free_tl + 1'b1;
        end
      end
      rob_cnt <= rob_cnt + {4'd0, m_acc} - {4'd0, m_retire};
    end
  end

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  a_stall : assert property (@(posedge core_clock) disable iff (!rst_n)
    ren_stall == m_full)
    else stop_run($sformatf("mismatch at %0t ns: ren_stall_o is %0b", $time, ren_stall));

  a_rs1_preg : assert property (@(posedge core_clock) disable iff (!rst_n)
    ren_rs1_preg == map_m[ren_rs1])
    else stop_run($sformatf("mismatch at %0t ns: rs1 maps to %0d, expected %0d",
                            $time, ren_rs1_preg, map_m[ren_rs1]));

  a_rs2_preg : assert property (@(posedge core_clock) disable iff (!rst_n)
    ren_rs2_preg == map_m[ren_rs2])
    else stop_run($sformatf("mismatch at %0t ns: rs2 maps to %0d, expected %0d",
                            $time, ren_rs2_preg, map_m[ren_rs2]));

  a_rs1_ready : assert property (@(posedge core_clock) disable iff (!rst_n)
    ren_rs1_ready == rdy_m[map_m[ren_rs1]])
    else stop_run($sformatf("mismatch at %0t ns: rs1 ready is %0b", $time, ren_rs1_ready));

  a_rs2_ready : assert property (@(posedge core_clock) disable iff (!rst_n)
    ren_rs2_ready == rdy_m[map_m[ren_rs2]])
    else stop_run($sformatf("mismatch at %0t ns: rs2 ready is %0b", $time, ren_rs2_ready));

  // New registers come from the head of the free FIFO
  a_dest_preg : assert property (@(posedge core_clock) disable iff (!rst_n)
    ren_dest_preg == (m_dest ? free_m[free_hd] : '0))
    else stop_run($sformatf("mismatch at %0t ns: destination got %0d, expected %0d",
                            $time, ren_dest_preg, free_m[free_hd]));

  a_rob_id : assert property (@(posedge core_clock) disable iff (!rst_n)
    ren_rob_id == rob_tl)
    else stop_run($sformatf("mismatch at %0t ns: rob id %0d, expected %0d",
                            $time, ren_rob_id, rob_tl));

  a_rd0 : assert property (@(posedge core_clock) disable iff (!rst_n)
    rd0_data == val_m[rd0_preg])
    else stop_run($sformatf("mismatch at %0t ns: p%0d reads %h, expected %h",
                            $time, rd0_preg, rd0_data, val_m[rd0_preg]));

  a_rd1 : assert property (@(posedge core_clock) disable iff (!rst_n)
    rd1_data == val_m[rd1_preg])
    else stop_run($sformatf("mismatch at %0t ns: p%0d reads %h, expected %h",
                            $time, rd1_preg, rd1_data, val_m[rd1_preg]));

  a_commit_pulse : assert property (@(posedge core_clock) disable iff (!rst_n)
    commit_valid == exp_cv)
    else stop_run($sformatf("mismatch at %0t ns: commit_valid_o is %0b", $time, commit_valid));

  a_commit_order : assert property (@(posedge core_clock) disable iff (!rst_n)
    commit_valid |-> (commit_arch == exp_carch && commit_preg == exp_cpreg))
    else stop_run($sformatf("mismatch at %0t ns: commit x%0d/p%0d, expected x%0d/p%0d",
                            $time, commit_arch, commit_preg, exp_carch, exp_cpreg));

  task automatic next_cycle();
    @(posedge core_clock);
    #2;
  endtask

  // Holds the instruction until rename accepts it
  task automatic rename_one(input logic has_dest, input logic [AREG_W-1:0] dest,
                            input logic [AREG_W-1:0] rs1, input logic [AREG_W-1:0] rs2);
    int waited;
    waited       = 0;
    ren_valid    = 1'b1;
    ren_has_dest = has_dest;
    ren_dest     = dest;
    ren_rs1      = rs1;
    ren_rs2      = rs2;
    #1;
    while (ren_stall) begin
      next_cycle();
      #1;
      waited++;
      if (waited > 50) begin
        stop_run("timeout: rename stayed stalled for 50 cycles");
      end
    end
    iss_rob[n_iss]  = ren_rob_id;
    iss_preg[n_iss] = ren_dest_preg;
    iss_dest[n_iss] = has_dest && (dest != '0);
    n_iss++;
    next_cycle();
    ren_valid = 1'b0;
  endtask

  // A negative second index leaves port 1 idle
  task automatic write_pair(input int a, input int b);
    wb0_valid  = 1'b1;
    wb0_rob_id = iss_rob[a];
    wb0_we     = iss_dest[a];
    wb0_preg   = iss_preg[a];
    wb0_data   = $random(seed);
    rd0_preg   = iss_preg[a];
    if (b >= 0) begin
      wb1_valid  = 1'b1;
      wb1_rob_id = iss_rob[b];
      wb1_we     = iss_dest[b];
      wb1_preg   = iss_preg[b];
      wb1_data   = $random(seed);
      rd1_preg   = iss_preg[b];
    end
    next_cycle();
    wb0_valid = 1'b0;
    wb0_we    = 1'b0;
    wb1_valid = 1'b0;
    wb1_we    = 1'b0;
  endtask

  // Youngest first, so the head completes last
  task automatic complete_range(input int first, input int last);
    int i;
    i = last;
    while (i >= first) begin
      if (i > first) begin
        write_pair(i, i - 1);
      end else begin
        write_pair(i, -1);
      end
      i = i - 2;
    end
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (rob_cnt != '0 || exp_cv) begin
      next_cycle();
      waited++;
      if (waited > 40) begin
        stop_run("timeout: reorder buffer did not drain within 40 cycles");
      end
    end
  endtask

  initial begin
    int first;
    seed         = 46;
    n_iss        = 0;
    rst_n        = 1'b0;
    ren_valid    = 1'b0;
    ren_has_dest = 1'b0;
    ren_rs1      = '0;
    ren_rs2      = '0;
    ren_dest     = '0;
    wb0_valid    = 1'b0;
    wb0_rob_id   = '0;
    wb0_we       = 1'b0;
    wb0_preg     = '0;
    wb0_data     = '0;
    wb1_valid    = 1'b0;
    wb1_rob_id   = '0;
    wb1_we       = 1'b0;
    wb1_preg     = '0;
    wb1_data     = '0;
    rd0_preg     = '0;
    rd1_preg     = '0;
    repeat (8) @(posedge core_clock);
    #2;
    rst_n = 1'b1;

    // Identity mapping, all ready and zero after reset
    for (int r = 0; r < ARCH_REGS; r++) begin
      ren_rs1  = AREG_W'(r);
      ren_rs2  = AREG_W'(ARCH_REGS - 1 - r);
      rd0_preg = PREG_W'(r);
      rd1_preg = PREG_W'(r + ARCH_REGS);
      next_cycle();
    end

    // x0 as a destination must not take a register
    rename_one(1'b1, 5'd1, 5'd0, 5'd0);
    rename_one(1'b1, 5'd2, 5'd1, 5'd0);
    rename_one(1'b1, 5'd0, 5'd2, 5'd1);
    rename_one(1'b1, 5'd3, 5'd1, 5'd2);
    rename_one(1'b0, 5'd4, 5'd3, 5'd3);

    // Out of order completion, head last
    write_pair(3, 1);
    write_pair(4, 2);
    write_pair(0, -1);
    rename_one(1'b0, 5'd0, 5'd1, 5'd3);
    write_pair(5, -1);
    wait_drained();

    // Sixteen in flight fill the window, the seventeenth waits for a commit
    first = n_iss;
    for (int k = 0; k < ROB_DEPTH; k++) begin
      rename_one(1'b1, AREG_W'(8 + k), AREG_W'(k), AREG_W'(k + 1));
    end
    write_pair(first, -1);
    rename_one(1'b1, 5'd24, 5'd8, 5'd9);
    complete_range(first + 1, n_iss - 1);
    wait_drained();

    // Run past register 63 so that committed old registers get reused
    for (int round = 0; round < 3; round++) begin
      first = n_iss;
      for (int k = 0; k < 8; k++) begin
        rename_one(1'b1, AREG_W'(1 + ((round * 8 + k) % 31)), AREG_W'(k), AREG_W'(round));
      end
      complete_range(first, n_iss - 1);
      wait_drained();
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: rename_engine.sv
`timescale 1ns/1ps
`default_nettype none

module rename_engine import engine_pkg::*; (
  input  logic              core_clock_i,
  input  logic              rst_n_i,
  input  logic              ren_valid_i,
  input  logic              ren_has_dest_i,
  input  logic [AREG_W-1:0] ren_rs1_i,
  input  logic [AREG_W-1:0] ren_rs2_i,
  input  logic [AREG_W-1:0] ren_dest_i,
  output logic              ren_stall_o,
  output logic [PREG_W-1:0] ren_rs1_preg_o,
  output logic [PREG_W-1:0] ren_rs2_preg_o,
  output logic              ren_rs1_ready_o,
  output logic              ren_rs2_ready_o,
  output logic [PREG_W-1:0] ren_dest_preg_o,
  output logic [ROB_W-1:0]  ren_rob_id_o,
  input  logic              wb0_valid_i,
  input  logic [ROB_W-1:0]  wb0_rob_id_i,
  input  logic              wb0_we_i,
  input  logic [PREG_W-1:0] wb0_preg_i,
  input  logic [XLEN-1:0]   wb0_data_i,
  input  logic              wb1_valid_i,
  input  logic [ROB_W-1:0]  wb1_rob_id_i,
  input  logic              wb1_we_i,
  input  logic [PREG_W-1:0] wb1_preg_i,
  input  logic [XLEN-1:0]   wb1_data_i,
  input  logic [PREG_W-1:0] rd0_preg_i,
  output logic [XLEN-1:0]   rd0_data_o,
  input  logic [PREG_W-1:0] rd1_preg_i,
  output logic [XLEN-1:0]   rd1_data_o,
  output logic              commit_valid_o,
  output logic [AREG_W-1:0] commit_arch_o,
  output logic [PREG_W-1:0] commit_preg_o
);

  logic              alloc;
  logic              accept;
  logic              has_dest;
  logic [PREG_W-1:0] old_preg;
  logic [PREG_W-1:0] free_head;
  logic              rob_full;
  logic [ROB_W-1:0]  rob_tail;
  logic              free_en;
  logic [PREG_W-1:0] free_preg;
  logic              src_ready_a;
  logic              src_ready_b;

  phys_reg_file i_phys_reg_file (
    .core_clock_i (core_clock_i),
    .rst_n_i      (rst_n_i),
    .wr_0_en_i    (wb0_we_i),
    .wr_0_addr_i  (wb0_preg_i),
    .wr_0_data_i  (wb0_data_i),
    .wr_1_en_i    (wb1_we_i),
    .wr_1_addr_i  (wb1_preg_i),
    .wr_1_data_i  (wb1_data_i),
    .rd0_addr_i   (rd0_preg_i),
    .rd0_data_o   (rd0_data_o),
    .rd1_addr_i   (rd1_preg_i),
    .rd1_data_o   (rd1_data_o)
  );

  // Source lookups from rename feed straight into the ready check
  reg_status_table i_reg_status_table (
    .core_clock_i    (core_clock_i),
    .rst_n_i         (rst_n_i),
    .set_busy_en_i   (alloc),
    .set_busy_preg_i (free_head),
    .wake_0_en_i     (wb0_we_i),
    .wake_0_preg_i   (wb0_preg_i),
    .wake_1_en_i     (wb1_we_i),
    .wake_1_preg_i   (wb1_preg_i),
    .chk_a_preg_i    (ren_rs1_preg_o),
    .chk_a_ready_o   (src_ready_a),
    .chk_b_preg_i    (ren_rs2_preg_o),
    .chk_b_ready_o   (src_ready_b)
  );

  free_list i_free_list (
    .core_clock_i (core_clock_i),
    .rst_n_i      (rst_n_i),
    .pop_i        (alloc),
    .pop_preg_o   (free_head),
    .push_i       (free_en),
    .push_preg_i  (free_preg)
  );

  rename_stage i_rename_stage (
    .core_clock_i    (core_clock_i),
    .rst_n_i         (rst_n_i),
    .ren_valid_i     (ren_valid_i),
    .ren_has_dest_i  (ren_has_dest_i),
    .ren_rs1_i       (ren_rs1_i),
    .ren_rs2_i       (ren_rs2_i),
    .ren_dest_i      (ren_dest_i),
    .ren_stall_o     (ren_stall_o),
    .ren_rs1_preg_o  (ren_rs1_preg_o),
    .ren_rs2_preg_o  (ren_rs2_preg_o),
    .ren_rs1_ready_o (ren_rs1_ready_o),
    .ren_rs2_ready_o (ren_rs2_ready_o),
    .ren_dest_preg_o (ren_dest_preg_o),
    .ren_rob_id_o    (ren_rob_id_o),
    .rob_full_i      (rob_full),
    .rob_tail_i      (rob_tail),
    .free_preg_i     (free_head),
    .src_ready_a_i   (src_ready_a),
    .src_ready_b_i   (src_ready_b),
    .alloc_o         (alloc),
    .accept_o        (accept),
    .old_preg_o      (old_preg),
    .has_dest_o      (has_dest)
  );

  reorder_buffer i_reorder_buffer (
    .core_clock_i    (core_clock_i),
    .rst_n_i         (rst_n_i),
    .push_i          (accept),
    .push_arch_i     (ren_dest_i),
    .push_old_preg_i (old_preg),
    .push_new_preg_i (ren_dest_preg_o),
    .push_has_dest_i (has_dest),
    .wb_0_valid_i    (wb0_valid_i),
    .wb_0_rob_id_i   (wb0_rob_id_i),
    .wb_1_valid_i    (wb1_valid_i),
    .wb_1_rob_id_i   (wb1_rob_id_i),
    .tail_o          (rob_tail),
    .full_o          (rob_full),
    .free_en_o       (free_en),
    .free_preg_o     (free_preg),
    .commit_valid_o  (commit_valid_o),
    .commit_arch_o   (commit_arch_o),
    .commit_preg_o   (commit_preg_o)
  );

endmodule

`default_nettype wire

// File: reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer import engine_pkg::*; (
  input  logic              core_clock_i,
  input  logic              rst_n_i,
  input  logic              push_i,
  input  logic [AREG_W-1:0] push_arch_i,
  input  logic [PREG_W-1:0] push_old_preg_i,
  input  logic [PREG_W-1:0] push_new_preg_i,
  input  logic              push_has_dest_i,
  input  logic              wb_0_valid_i,
  input  logic [ROB_W-1:0]  wb_0_rob_id_i,
  input  logic              wb_1_valid_i,
  input  logic [ROB_W-1:0]  wb_1_rob_id_i,
  output logic [ROB_W-1:0]  tail_o,
  output logic              full_o,
  output logic              free_en_o,
  output logic [PREG_W-1:0] free_preg_o,
  output logic              commit_valid_o,
  output logic [AREG_W-1:0] commit_arch_o,
  output logic [PREG_W-1:0] commit_preg_o
);

  logic [AREG_W-1:0]    arch_q     [ROB_DEPTH];
  logic [PREG_W-1:0]    old_preg_q [ROB_DEPTH];
  logic [PREG_W-1:0]    new_preg_q [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] has_dest_q;
  logic [ROB_DEPTH-1:0] done_q;
  logic [ROB_W-1:0]     head_q;
  logic [ROB_W-1:0]     tail_q;
  logic [ROB_W:0]       count_q;
  logic                 retire;
  logic [ROB_W-1:0]     wb0_offset;
  logic [ROB_W-1:0]     wb1_offset;

  assign tail_o = tail_q;
  assign full_o = (count_q == (ROB_W + 1)'(ROB_DEPTH));

  // The head leaves as soon as its completion flag is set
  assign retire      = (count_q != '0) && done_q[head_q];
  assign free_en_o   = retire && has_dest_q[head_q];
  assign free_preg_o = old_preg_q[head_q];

  always_ff @(posedge core_clock_i) begin
    if (push_i) begin
      arch_q[tail_q]     <= push_arch_i;
      old_preg_q[tail_q] <= push_old_preg_i;
      new_preg_q[tail_q] <= push_new_preg_i;
      has_dest_q[tail_q] <= push_has_dest_i;
    end
  end

  always_ff @(posedge core_clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_q <= '0;
    end else begin
      if (push_i) begin
        done_q[tail_q] <= 1'b0;
      end
      if (wb_0_valid_i) begin
        done_q[wb_0_rob_id_i] <= 1'b1;
      end
      if (wb_1_valid_i) begin
        done_q[wb_1_rob_id_i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge core_clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (push_i) begin
        tail_q <= tail_q + 1'b1;
      end
      if (retire) begin
        head_q <= head_q + 1'b1;
      end
      case ({push_i, retire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Commit is reported one cycle after the entry leaves the window
  always_ff @(posedge core_clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      commit_valid_o <= 1'b0;
      commit_arch_o  <= '0;
      commit_preg_o  <= '0;
    end else begin
      commit_valid_o <= retire;
      if (retire) begin
        commit_arch_o <= arch_q[head_q];
        commit_preg_o <= new_preg_q[head_q];
      end
    end
  end

  // Distance from the head tells whether a slot is occupied
  assign wb0_offset = wb_0_rob_id_i - head_q;
  assign wb1_offset = wb_1_rob_id_i - head_q;

  a_wb_to_live_slot : assert property (
    @(posedge core_clock_i) disable iff (!rst_n_i)
    (wb_0_valid_i |-> ({1'b0, wb0_offset} < count_q)) and
    (wb_1_valid_i |-> ({1'b0, wb1_offset} < count_q))
  );

endmodule

`default_nettype wire

// File: rename_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rename_stage import engine_pkg::*; (
  input  logic              core_clock_i,
  input  logic              rst_n_i,
  input  logic              ren_valid_i,
  input  logic              ren_has_dest_i,
  input  logic [AREG_W-1:0] ren_rs1_i,
  input  logic [AREG_W-1:0] ren_rs2_i,
  input  logic [AREG_W-1:0] ren_dest_i,
  output logic              ren_stall_o,
  output logic [PREG_W-1:0] ren_rs1_preg_o,
  output logic [PREG_W-1:0] ren_rs2_preg_o,
  output logic              ren_rs1_ready_o,
  output logic              ren_rs2_ready_o,
  output logic [PREG_W-1:0] ren_dest_preg_o,
  output logic [ROB_W-1:0]  ren_rob_id_o,
  input  logic              rob_full_i,
  input  logic [ROB_W-1:0]  rob_tail_i,
  input  logic [PREG_W-1:0] free_preg_i,
  input  logic              src_ready_a_i,
  input  logic              src_ready_b_i,
  output logic              alloc_o,
  output logic              accept_o,
  output logic [PREG_W-1:0] old_preg_o,
  output logic              has_dest_o
);

  logic [PREG_W-1:0] map_q [ARCH_REGS];

  // x0 is hardwired, so it never takes a new physical register
  assign has_dest_o = ren_has_dest_i && (ren_dest_i != '0);

  // The reorder buffer is the only source of back-pressure
  assign ren_stall_o = rob_full_i;
  assign accept_o    = ren_valid_i && !rob_full_i;
  assign alloc_o     = accept_o && has_dest_o;

  // Sources see the mapping before this instruction's own update
  assign ren_rs1_preg_o  = map_q[ren_rs1_i];
  assign ren_rs2_preg_o  = map_q[ren_rs2_i];
  assign ren_rs1_ready_o = src_ready_a_i;
  assign ren_rs2_ready_o = src_ready_b_i;

  // The previous mapping is released once this instruction commits
  assign old_preg_o      = map_q[ren_dest_i];
  assign ren_dest_preg_o = has_dest_o ? free_preg_i : '0;
  assign ren_rob_id_o    = rob_tail_i;

  always_ff @(posedge core_clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < ARCH_REGS; i++) begin
        map_q[i] <= PREG_W'(i);
      end
    end else if (alloc_o) begin
      map_q[ren_dest_i] <= free_preg_i;
    end
  end

endmodule

`default_nettype wire

// File: free_list.sv
`timescale 1ns/1ps
`default_nettype none

module free_list import engine_pkg::*; (
  input  logic              core_clock_i,
  input  logic              rst_n_i,
  input  logic              pop_i,
  output logic [PREG_W-1:0] pop_preg_o,
  input  logic              push_i,
  input  logic [PREG_W-1:0] push_preg_i
);

  logic [PREG_W-1:0]             fifo_q [FREE_DEPTH];
  logic [$clog2(FREE_DEPTH)-1:0] head_q;
  logic [$clog2(FREE_DEPTH)-1:0] tail_q;
  // The free count never exceeds the physical register total
  logic [PREG_W-1:0]             count_q;

  // Registers above the identity mapping start free in ascending order
  always_ff @(posedge core_clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < FREE_DEPTH; i++) begin
        fifo_q[i] <= PREG_W'(ARCH_REGS + i);
      end
    end else if (push_i) begin
      fifo_q[tail_q] <= push_preg_i;
    end
  end

  always_ff @(posedge core_clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= PREG_W'(FREE_DEPTH);
    end else begin
      if (pop_i) begin
        head_q <= head_q + 1'b1;
      end
      if (push_i) begin
        tail_q <= tail_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // The head entry is offered before the pop is known
  assign pop_preg_o = fifo_q[head_q];

  // The window is smaller than the free pool, so rename never finds it empty
  a_no_underflow : assert property (
    @(posedge core_clock_i) disable iff (!rst_n_i)
    pop_i |-> (count_q != '0)
  );

  // A commit only returns a register that rename took out earlier
  a_no_overflow : assert property (
    @(posedge core_clock_i) disable iff (!rst_n_i)
    push_i |-> (count_q != PREG_W'(FREE_DEPTH))
  );

endmodule

`default_nettype wire

// File: reg_status_table.sv
`timescale 1ns/1ps
`default_nettype none

module reg_status_table import engine_pkg::*; (
  input  logic              core_clock_i,
  input  logic              rst_n_i,
  input  logic              set_busy_en_i,
  input  logic [PREG_W-1:0] set_busy_preg_i,
  input  logic              wake_0_en_i,
  input  logic [PREG_W-1:0] wake_0_preg_i,
  input  logic              wake_1_en_i,
  input  logic [PREG_W-1:0] wake_1_preg_i,
  input  logic [PREG_W-1:0] chk_a_preg_i,
  output logic              chk_a_ready_o,
  input  logic [PREG_W-1:0] chk_b_preg_i,
  output logic              chk_b_ready_o
);

  logic [PHYS_REGS-1:0] ready_q;

  always_ff @(posedge core_clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_q <= '1;
    end else begin
      if (wake_0_en_i) begin
        ready_q[wake_0_preg_i] <= 1'b1;
      end
      if (wake_1_en_i) begin
        ready_q[wake_1_preg_i] <= 1'b1;
      end
      // A freshly allocated register waits for its producer
      if (set_busy_en_i) begin
        ready_q[set_busy_preg_i] <= 1'b0;
      end
    end
  end

  assign chk_a_ready_o = ready_q[chk_a_preg_i];
  assign chk_b_ready_o = ready_q[chk_b_preg_i];

  // A register handed out by the free list has no producer in flight yet
  a_no_alloc_wake_clash : assert property (
    @(posedge core_clock_i) disable iff (!rst_n_i)
    set_busy_en_i |-> !(wake_0_en_i && wake_0_preg_i == set_busy_preg_i) &&
                      !(wake_1_en_i && wake_1_preg_i == set_busy_preg_i)
  );

endmodule

`default_nettype wire

// File: phys_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module phys_reg_file import engine_pkg::*; (
  input  logic              core_clock_i,
  input  logic              rst_n_i,
  input  logic              wr_0_en_i,
  input  logic [PREG_W-1:0] wr_0_addr_i,
  input  logic [XLEN-1:0]   wr_0_data_i,
  input  logic              wr_1_en_i,
  input  logic [PREG_W-1:0] wr_1_addr_i,
  input  logic [XLEN-1:0]   wr_1_data_i,
  input  logic [PREG_W-1:0] rd0_addr_i,
  output logic [XLEN-1:0]   rd0_data_o,
  input  logic [PREG_W-1:0] rd1_addr_i,
  output logic [XLEN-1:0]   rd1_data_o
);

  logic [XLEN-1:0] regs_q [PHYS_REGS];

  // Each writeback port owns its own write port, so no arbitration is needed
  always_ff @(posedge core_clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < PHYS_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      if (wr_0_en_i) begin
        regs_q[wr_0_addr_i] <= wr_0_data_i;
      end
      if (wr_1_en_i) begin
        regs_q[wr_1_addr_i] <= wr_1_data_i;
      end
    end
  end

  // Reads see the array contents only, a write lands at the next edge
  assign rd0_data_o = regs_q[rd0_addr_i];
  assign rd1_data_o = regs_q[rd1_addr_i];

  // Only one producer can own a physical register, so the two
  // execution pipes must never write the same one together
  a_no_dual_write : assert property (
    @(posedge core_clock_i) disable iff (!rst_n_i)
    (wr_0_en_i && wr_1_en_i) |-> (wr_0_addr_i != wr_1_addr_i)
  );

endmodule

`default_nettype wire

// File: engine_pkg.sv
`default_nettype none

package engine_pkg;

  // Architectural register file as seen by software
  localparam int ARCH_REGS = 32;
  localparam int AREG_W = 5;

  // Physical register pool shared by the map table and the free list
  localparam int PHYS_REGS = 64;
  localparam int PREG_W = 6;

  // Data word width of the register file
  localparam int XLEN = 32;

  // Reorder buffer window
  localparam int ROB_DEPTH = 16;
  localparam int ROB_W = 4;

  // Registers beyond the identity mapping start out free
  localparam int FREE_DEPTH = PHYS_REGS - ARCH_REGS;

endpackage

`default_nettype wire
